// ==== design/n8x300_pkg.sv ====
`default_nettype none

package n8x300_pkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 13;
	localparam int REG_AW = 3;

	// opcode field, top three bits of every word
	localparam logic [2:0] OP_MOVE = 3'd0;
	localparam logic [2:0] OP_ADD  = 3'd1;
	localparam logic [2:0] OP_AND  = 3'd2;
	localparam logic [2:0] OP_XOR  = 3'd3;
	localparam logic [2:0] OP_XMIT = 3'd6;
	localparam logic [2:0] OP_JMP  = 3'd7;

	localparam logic [4:0] SRC_OVF = 5'o10;
	localparam logic [4:0] REG_R11 = 5'o11;	// aux register, file entry 7
	localparam logic [4:0] DST_IVL = 5'o07;

	localparam logic [1:0] ALU_PASS = 2'd0;
	localparam logic [1:0] ALU_ADD  = 2'd1;
	localparam logic [1:0] ALU_AND  = 2'd2;
	localparam logic [1:0] ALU_XOR  = 2'd3;

	typedef struct packed
	{
		logic [2:0] op;
		logic [4:0] src;
		logic [2:0] rot;
		logic [4:0] dst;
	} reg_fmt_t;

	typedef struct packed
	{
		logic [2:0]        op;
		logic [4:0]        dst;
		logic [DATA_W-1:0] lit;
	} imm_fmt_t;

	typedef struct packed
	{
		logic [2:0]        op;
		logic [ADDR_W-1:0] target;
	} jmp_fmt_t;

	typedef union packed
	{
		reg_fmt_t r;
		imm_fmt_t i;
		jmp_fmt_t j;
	} instr_u;

	// all zero is a bubble
	typedef struct packed
	{
		logic [1:0]        alu;
		logic              use_lit;
		logic [DATA_W-1:0] lit;
		logic [2:0]        rot;
		logic              ovf_src;
		logic              wr_en;
		logic [REG_AW-1:0] wr_addr;
		logic              sc;
	} ctrl_t;

	typedef struct packed
	{
		logic              valid;
		logic [ADDR_W-1:0] target;
	} jump_t;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
	parameter int ADDR_W = n8x300_pkg::ADDR_W
) (
	input  wire                    clk,
	input  wire                    RST,
	input  wire                    stall,
	input  wire n8x300_pkg::jump_t jump,
	output logic [ADDR_W-1:0]      addr
);

	logic [ADDR_W-1:0] pc;

	always_ff @(posedge clk)
	begin
		if (RST)
		begin
			pc <= '0;
		end
		else if (jump.valid)
		begin
			pc <= jump.target;	// next edge fetches the target
		end
		else if (!stall)
		begin
			pc <= pc + 1'b1;
		end
	end

	assign addr = pc;

	// decode holds its word under stall, so the bus must not move either
	addr_held: assert property (@(posedge clk) disable iff (RST)
		(stall && !jump.valid) |=> $stable(addr));

endmodule

`default_nettype wire

// ==== design/decode_unit.sv ====
`default_nettype none

module decode_unit (
	input  wire                            clk,
	input  wire                            RST,
	input  wire                            stall,
	input  wire  [15:0]                    instr,
	output n8x300_pkg::ctrl_t              ctrl,
	output logic [n8x300_pkg::REG_AW-1:0]  rd_addr,
	output logic                           rd_is_reg,
	output logic                           uses_r0,
	output logic                           reads_ovf,
	output n8x300_pkg::jump_t              jump
);

	localparam logic [15:0] BUBBLE = 16'h8000;	// opcode 4, decodes to nothing

	n8x300_pkg::instr_u ir;
	logic [4:0] dst_code;
	logic       is_alu;
	logic       is_xmit;
	logic       src_reg;
	logic       src_ovf;
	logic       dst_reg;
	logic       dst_iv;
	logic       legal;
	logic [1:0] alu_fn;

	// r11 lands in entry 7
	function automatic logic [n8x300_pkg::REG_AW-1:0] reg_index(input logic [4:0] code);
		reg_index = (code == n8x300_pkg::REG_R11) ? {n8x300_pkg::REG_AW{1'b1}}
			: code[n8x300_pkg::REG_AW-1:0];
	endfunction

	always_ff @(posedge clk)
	begin
		if (RST || jump.valid)
			ir <= BUBBLE;	// squash the word fetched behind a jump
		else if (!stall)
			ir <= instr;
	end

	assign is_alu = ir.r.op inside {n8x300_pkg::OP_MOVE, n8x300_pkg::OP_ADD,
		n8x300_pkg::OP_AND, n8x300_pkg::OP_XOR};
	assign is_xmit = ir.r.op == n8x300_pkg::OP_XMIT;

	// xmit keeps its destination where the register format has the source
	assign dst_code = is_xmit ? ir.i.dst : ir.r.dst;

	assign src_reg = (ir.r.src <= 5'd6) || (ir.r.src == n8x300_pkg::REG_R11);
	assign src_ovf = ir.r.src == n8x300_pkg::SRC_OVF;
	assign dst_reg = (dst_code <= 5'd6) || (dst_code == n8x300_pkg::REG_R11);
	assign dst_iv = dst_code == n8x300_pkg::DST_IVL;
	assign legal = (dst_reg || dst_iv) && (is_xmit || (is_alu && (src_reg || src_ovf)));

	always_comb
	begin
		case (ir.r.op)
		n8x300_pkg::OP_ADD: alu_fn = n8x300_pkg::ALU_ADD;
		n8x300_pkg::OP_AND: alu_fn = n8x300_pkg::ALU_AND;
		n8x300_pkg::OP_XOR: alu_fn = n8x300_pkg::ALU_XOR;
		default: alu_fn = n8x300_pkg::ALU_PASS;
		endcase
	end

	always_comb
	begin
		ctrl = '0;
		rd_addr = '0;
		rd_is_reg = 1'b0;
		uses_r0 = 1'b0;
		reads_ovf = 1'b0;
		if (legal)
		begin
			ctrl.wr_en = dst_reg;
			ctrl.wr_addr = reg_index(dst_code);
			ctrl.sc = dst_iv;
			if (is_xmit)
			begin
				ctrl.use_lit = 1'b1;
				ctrl.lit = ir.i.lit;
			end
			else
			begin
				ctrl.alu = alu_fn;
				ctrl.rot = ir.r.rot;
				ctrl.ovf_src = src_ovf;
				rd_addr = reg_index(ir.r.src);
				rd_is_reg = src_reg;
				reads_ovf = src_ovf;
				uses_r0 = alu_fn != n8x300_pkg::ALU_PASS;	// second operand is r0
			end
		end
	end

	assign jump = '{valid: (ir.r.op == n8x300_pkg::OP_JMP) && !stall, target: ir.j.target};

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
	input  wire                           halt,
	input  wire [n8x300_pkg::REG_AW-1:0]  rd_addr,
	input  wire                           rd_is_reg,
	input  wire                           uses_r0,
	input  wire                           reads_ovf,
	input  wire n8x300_pkg::ctrl_t        stage1,
	input  wire n8x300_pkg::ctrl_t        stage2,
	input  wire n8x300_pkg::ctrl_t        stage3,
	output logic                          stall
);

	logic raw_hit;
	logic aux_hit;
	logic ovf_hit;

	function automatic logic pending(input n8x300_pkg::ctrl_t s,
		input logic [n8x300_pkg::REG_AW-1:0] a);
		pending = s.wr_en && (s.wr_addr == a);
	endfunction

	// source register is read at issue, written three edges later
	assign raw_hit = rd_is_reg && (pending(stage1, rd_addr) || pending(stage2, rd_addr)
		|| pending(stage3, rd_addr));

	// r0 is read two edges after issue
	assign aux_hit = uses_r0 && pending(stage1, '0);

	assign ovf_hit = reads_ovf && (stage1.alu == n8x300_pkg::ALU_ADD);

	assign stall = halt || raw_hit || aux_hit || ovf_hit;

endmodule

`default_nettype wire

// ==== design/ctrl_pipe.sv ====
`default_nettype none

module ctrl_pipe (
	input  wire                    clk,
	input  wire                    RST,
	input  wire                    stall,
	input  wire n8x300_pkg::ctrl_t ctrl_in,
	output n8x300_pkg::ctrl_t      stage1,
	output n8x300_pkg::ctrl_t      stage2,
	output n8x300_pkg::ctrl_t      stage3
);

	always_ff @(posedge clk)
	begin
		if (RST)
		begin
			stage1 <= '0;
			stage2 <= '0;
			stage3 <= '0;
		end
		else
		begin
			if (stall)
				stage1 <= '0;	// bubble, decode keeps the word
			else
				stage1 <= ctrl_in;
			stage2 <= stage1;	// later stages always drain
			stage3 <= stage2;
		end
	end

	// a slot with no write and no strobe must be a clean bubble
	bubble_inert: assert property (@(posedge clk) disable iff (RST)
		(!stage3.wr_en && !stage3.sc) |-> (stage3 == '0));

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file #(
	parameter int DATA_W = n8x300_pkg::DATA_W
) (
	input  wire                           clk,
	input  wire [n8x300_pkg::REG_AW-1:0]  rd_addr,
	input  wire                           wr_en,
	input  wire [n8x300_pkg::REG_AW-1:0]  wr_addr,
	input  wire [DATA_W-1:0]              wr_data,
	output logic [DATA_W-1:0]             a_data,
	output logic [DATA_W-1:0]             r0_data
);

	logic [DATA_W-1:0] regs [0:(1 << n8x300_pkg::REG_AW)-1];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			regs[wr_addr] <= wr_data;
		a_data <= regs[rd_addr];	// read before write on the same edge
	end

	assign r0_data = regs[0];	// aux operand for the alu

	// write address comes out of the control pipe
	wr_addr_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`default_nettype none

module exec_unit #(
	parameter int DATA_W = n8x300_pkg::DATA_W
) (
	input  wire                    clk,
	input  wire                    RST,
	input  wire n8x300_pkg::ctrl_t stage1,
	input  wire n8x300_pkg::ctrl_t stage2,
	input  wire n8x300_pkg::ctrl_t stage3,
	input  wire [DATA_W-1:0]       a_data,
	input  wire [DATA_W-1:0]       r0_data,
	output logic [DATA_W-1:0]      result,
	output logic [DATA_W-1:0]      iv_out,
	output logic                   sc
);

	logic [DATA_W-1:0]   rot_src;
	logic [2*DATA_W-1:0] rot_dbl;
	logic [DATA_W-1:0]   rot_q;
	logic [DATA_W-1:0]   opa;
	logic [DATA_W:0]     sum;
	logic [DATA_W-1:0]   alu_out;
	logic                ovf_q;

	assign rot_src = stage1.ovf_src ? {{(DATA_W-1){1'b0}}, ovf_q} : a_data;
	assign rot_dbl = {rot_src, rot_src} >> stage1.rot;	// right rotate

	// xmit literal replaces the rotator output
	assign opa = stage2.use_lit ? stage2.lit : rot_q;
	assign sum = {1'b0, opa} + {1'b0, r0_data};

	always_comb
	begin
		alu_out = opa;
		case (stage2.alu)
		n8x300_pkg::ALU_PASS: alu_out = opa;
		n8x300_pkg::ALU_ADD: alu_out = sum[DATA_W-1:0];
		n8x300_pkg::ALU_AND: alu_out = opa & r0_data;
		n8x300_pkg::ALU_XOR: alu_out = opa ^ r0_data;
		endcase
	end

	always_ff @(posedge clk)
	begin
		rot_q <= rot_dbl[DATA_W-1:0];
		result <= alu_out;
		if (stage3.sc)
			iv_out <= result;	// bus keeps the last byte
	end

	always_ff @(posedge clk)
	begin
		if (RST)
		begin
			ovf_q <= 1'b0;
			sc <= 1'b0;
		end
		else
		begin
			if (stage2.alu == n8x300_pkg::ALU_ADD)
				ovf_q <= sum[DATA_W];	// carry out
			sc <= stage3.sc;
		end
	end

endmodule

`default_nettype wire

// ==== design/n8x300_core.sv ====
`default_nettype none

module n8x300_core #(
	parameter int DATA_W = n8x300_pkg::DATA_W,
	parameter int ADDR_W = n8x300_pkg::ADDR_W
) (
	input  wire                clk,
	input  wire                RST,
	input  wire                halt,
	input  wire  [15:0]        instr,
	output logic [ADDR_W-1:0]  addr,
	output logic [DATA_W-1:0]  iv_out,
	output logic               sc
);

	n8x300_pkg::ctrl_t ctrl;
	n8x300_pkg::ctrl_t stage1;
	n8x300_pkg::ctrl_t stage2;
	n8x300_pkg::ctrl_t stage3;
	n8x300_pkg::jump_t jump;
	logic [n8x300_pkg::REG_AW-1:0] rd_addr;
	logic rd_is_reg;
	logic uses_r0;
	logic reads_ovf;
	logic stall;
	logic [DATA_W-1:0] a_data;
	logic [DATA_W-1:0] r0_data;
	logic [DATA_W-1:0] result;

	fetch_unit #(.ADDR_W(ADDR_W)) fetch_i (
		.clk   (clk),
		.RST   (RST),
		.stall (stall),
		.jump  (jump),
		.addr  (addr)
	);

	decode_unit decode_i (
		.clk       (clk),
		.RST       (RST),
		.stall     (stall),
		.instr     (instr),
		.ctrl      (ctrl),
		.rd_addr   (rd_addr),
		.rd_is_reg (rd_is_reg),
		.uses_r0   (uses_r0),
		.reads_ovf (reads_ovf),
		.jump      (jump)
	);

	hazard_unit hazard_i (
		.halt      (halt),
		.rd_addr   (rd_addr),
		.rd_is_reg (rd_is_reg),
		.uses_r0   (uses_r0),
		.reads_ovf (reads_ovf),
		.stage1    (stage1),
		.stage2    (stage2),
		.stage3    (stage3),
		.stall     (stall)
	);

	ctrl_pipe pipe_i (
		.clk     (clk),
		.RST     (RST),
		.stall   (stall),
		.ctrl_in (ctrl),
		.stage1  (stage1),
		.stage2  (stage2),
		.stage3  (stage3)
	);

	// write-back from stage 3
	reg_file #(.DATA_W(DATA_W)) rf_i (
		.clk     (clk),
		.rd_addr (rd_addr),
		.wr_en   (stage3.wr_en),
		.wr_addr (stage3.wr_addr),
		.wr_data (result),
		.a_data  (a_data),
		.r0_data (r0_data)
	);

	exec_unit #(.DATA_W(DATA_W)) exec_i (
		.clk     (clk),
		.RST     (RST),
		.stage1  (stage1),
		.stage2  (stage2),
		.stage3  (stage3),
		.a_data  (a_data),
		.r0_data (r0_data),
		.result  (result),
		.iv_out  (iv_out),
		.sc      (sc)
	);

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
`default_nettype none

module clk_gen #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== verif/tb_n8x300.sv ====
`default_nettype none

module tb_n8x300;

	localparam int ROM_N = 1 << n8x300_pkg::ADDR_W;
	localparam logic [4:0] IVL = n8x300_pkg::DST_IVL;
	localparam logic [4:0] R11 = n8x300_pkg::REG_R11;

	logic clk;
	logic RST = 1'b1;
	logic halt = 1'b0;
	logic [15:0] instr = '0;
	logic [n8x300_pkg::ADDR_W-1:0] addr;
	logic [n8x300_pkg::DATA_W-1:0] iv_out;
	logic sc;

	logic [15:0] rom [0:ROM_N-1];
	logic [7:0] exp_q [$];
	string test_name = "";
	int seed = 7;
	int cycles = 0;
	int limit = 1000;
	int got = 0;
	int errors = 0;
	int test_err = 0;
	int n_tests = 0;
	int n_failed = 0;
	bit checking = 1'b0;
	bit halt_en = 1'b0;
	logic halt_seen = 1'b0;
	logic [n8x300_pkg::ADDR_W-1:0] addr_seen = '0;
	logic [n8x300_pkg::ADDR_W-1:0] rst_addr;
	logic rst_sc;

	clk_gen #(.PERIOD(100)) clk_i (.clk(clk));

	n8x300_core #(
		.DATA_W (n8x300_pkg::DATA_W),
		.ADDR_W (n8x300_pkg::ADDR_W)
	) dut_i (
		.clk    (clk),
		.RST    (RST),
		.halt   (halt),
		.instr  (instr),
		.addr   (addr),
		.iv_out (iv_out),
		.sc     (sc)
	);

	function automatic logic [15:0] enc_r(input logic [2:0] op, input logic [4:0] src,
		input logic [2:0] rot, input logic [4:0] dst);
		return {op, src, rot, dst};
	endfunction

	function automatic logic [15:0] enc_x(input logic [4:0] dst, input logic [7:0] lit);
		return {n8x300_pkg::OP_XMIT, dst, lit};
	endfunction

	function automatic logic [15:0] enc_j(input int target);
		return {n8x300_pkg::OP_JMP, target[12:0]};
	endfunction

	task automatic load_prog(input int prog);
		int a;
		for (a = 0; a < ROM_N; a++)
			rom[a] = enc_j(a);	// unused words jump to themselves
		case (prog)
		1:
		begin
			rom[0] = enc_x(5'd1, 8'h12);
			rom[1] = enc_x(IVL, 8'hA5);
			rom[2] = enc_x(IVL, 8'h3C);
			rom[3] = enc_x(5'd2, 8'h77);
			rom[4] = enc_r(n8x300_pkg::OP_MOVE, 5'd1, 3'd0, IVL);
			rom[5] = enc_r(n8x300_pkg::OP_MOVE, 5'd2, 3'd0, IVL);
			rom[6] = enc_j(6);
		end
		2:
		begin
			rom[0] = enc_x(5'd0, 8'h0F);
			rom[1] = enc_x(5'd1, 8'h81);
			rom[2] = enc_r(n8x300_pkg::OP_MOVE, 5'd1, 3'd1, 5'd2);
			rom[3] = enc_r(n8x300_pkg::OP_ADD, 5'd2, 3'd0, 5'd3);	// needs r2 at once
			rom[4] = enc_r(n8x300_pkg::OP_AND, 5'd3, 3'd4, IVL);
			rom[5] = enc_r(n8x300_pkg::OP_XOR, 5'd3, 3'd2, 5'd0);
			rom[6] = enc_r(n8x300_pkg::OP_ADD, 5'd1, 3'd0, IVL);	// new r0
			rom[7] = enc_x(R11, 8'h5A);
			rom[8] = enc_r(n8x300_pkg::OP_MOVE, R11, 3'd3, IVL);
			rom[9] = enc_r(n8x300_pkg::OP_XOR, 5'd0, 3'd7, IVL);
			rom[10] = enc_j(10);
		end
		3:
		begin
			rom[0] = enc_x(5'd0, 8'hF0);
			rom[1] = enc_x(5'd1, 8'h20);
			rom[2] = enc_r(n8x300_pkg::OP_ADD, 5'd1, 3'd0, 5'd2);	// carries
			rom[3] = enc_r(n8x300_pkg::OP_MOVE, n8x300_pkg::SRC_OVF, 3'd0, IVL);
			rom[4] = enc_x(5'd1, 8'h01);
			rom[5] = enc_r(n8x300_pkg::OP_ADD, 5'd1, 3'd0, 5'd2);
			rom[6] = enc_r(n8x300_pkg::OP_MOVE, n8x300_pkg::SRC_OVF, 3'd0, IVL);
			rom[7] = enc_j(7);
		end
		default:
		begin
			rom[0] = enc_x(IVL, 8'h11);
			rom[1] = enc_j(4);
			rom[2] = enc_x(IVL, 8'hEE);
			rom[3] = enc_x(IVL, 8'hDD);
			rom[4] = enc_x(IVL, 8'h44);
			rom[5] = enc_j(5);
		end
		endcase
	endtask

	// ISA-level model, fills exp_q and returns the executed instruction count
	function automatic int interpret();
		logic [7:0] r [0:7];
		logic [15:0] w;
		logic [2:0] op;
		logic [4:0] src;
		logic [4:0] dst;
		logic [7:0] v;
		logic [8:0] s;
		logic ovf;
		logic ok;
		int pc;
		int n;
		int k;
		exp_q.delete();
		for (k = 0; k < 8; k++)
			r[k] = 8'h00;
		ovf = 1'b0;
		pc = 0;
		n = 0;
		while (n < 1000)
		begin
			w = rom[pc];
			op = w[15:13];
			n++;
			if (op == n8x300_pkg::OP_JMP)
			begin
				if (int'(w[12:0]) == pc)
					break;
				pc = int'(w[12:0]);
				continue;
			end
			pc++;
			dst = (op == n8x300_pkg::OP_XMIT) ? w[12:8] : w[4:0];
			src = w[12:8];
			v = 8'h00;
			ok = (dst <= 5'd6) || (dst == R11) || (dst == IVL);
			if (op == n8x300_pkg::OP_XMIT)
				v = w[7:0];
			else if (op <= n8x300_pkg::OP_XOR && (src <= 5'd6 || src == R11))
				v = r[(src == R11) ? 7 : src];
			else if (op <= n8x300_pkg::OP_XOR && src == n8x300_pkg::SRC_OVF)
				v = {7'd0, ovf};
			else
				ok = 1'b0;	// opcodes 4, 5 and reserved sources
			if (ok && op != n8x300_pkg::OP_XMIT)
			begin
				repeat (w[7:5]) v = {v[0], v[7:1]};
				if (op == n8x300_pkg::OP_ADD)
				begin
					s = v + r[0];
					v = s[7:0];
					ovf = s[8];
				end
				else if (op == n8x300_pkg::OP_AND)
					v = v & r[0];
				else if (op == n8x300_pkg::OP_XOR)
					v = v ^ r[0];
			end
			if (ok && dst == IVL)
				exp_q.push_back(v);
			else if (ok)
				r[(dst == R11) ? 7 : dst] = v;
		end
		return n;
	endfunction

	always @(posedge clk)
	begin
		#10;
		instr = rom[addr];
		halt = halt_en && (($random(seed) & 3) == 0);
	end

	always @(negedge clk)
	begin
		if (checking && sc)
		begin
			if (got >= exp_q.size())
			begin
				$display("ERROR %s: output byte %h arrived after the last expected one",
					test_name, iv_out);
				errors++;
				test_err++;
			end
			else if (iv_out !== exp_q[got])
			begin
				$display("ERROR %s: expected %h, actual %h", test_name, exp_q[got], iv_out);
				errors++;
				test_err++;
			end
			got++;
		end
		if (checking && halt_seen && addr !== addr_seen)
		begin
			$display("%s: addr moved from %h to %h while halt was high",
				test_name, addr_seen, addr);
			errors++;
			test_err++;
		end
		halt_seen = halt;
		addr_seen = addr;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("%s timed out after %0d cycles with %0d bytes seen", test_name, cycles, got);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic do_reset();
		@(posedge clk);
		#10;
		RST = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_addr = addr;
		rst_sc = sc;
		@(posedge clk);
		#10;
		RST = 1'b0;
	endtask

	task automatic finish_test(input string name);
		n_tests++;
		if (test_err != 0)
			n_failed++;
		$display("%s: %0d bytes checked, %0d errors", name, got, test_err);
	endtask

	task automatic run_test(input string name, input int prog, input bit use_halt);
		int n_exec;
		int n_exp;
		load_prog(prog);
		n_exec = interpret();
		n_exp = exp_q.size();
		limit = cycles + 30 * n_exec + 200;
		do_reset();
		test_name = name;
		got = 0;
		test_err = 0;
		halt_en = use_halt;
		checking = 1'b1;
		while (got < n_exp)
			@(posedge clk);
		repeat (8) @(posedge clk);	// drain, stray strobes would show here
		checking = 1'b0;
		halt_en = 1'b0;
		finish_test(name);
	endtask

	initial
	begin
		run_test("xmit_out", 1, 1'b0);
		run_test("alu_rotate", 2, 1'b0);
		run_test("overflow", 3, 1'b0);
		run_test("jump_skip", 4, 1'b0);
		run_test("halt_stall", 2, 1'b1);
		test_name = "reset_state";
		got = 0;
		test_err = 0;
		limit = cycles + 200;
		do_reset();
		if (rst_addr !== '0 || rst_sc !== 1'b0)
		begin
			$display("ERROR reset_state: expected addr 0000 sc 0, actual addr %h sc %b",
				rst_addr, rst_sc);
			errors++;
			test_err++;
		end
		finish_test("reset_state");
		$display("%0d tests, %0d failing, %0d errors", n_tests, n_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== n8x300.f ====
design/n8x300_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/hazard_unit.sv
design/ctrl_pipe.sv
design/reg_file.sv
design/exec_unit.sv
design/n8x300_core.sv
verif/clk_gen.sv
verif/tb_n8x300.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass or fail comes from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_n8x300 \
	-f n8x300.f -o sim_n8x300 && ./obj_dir/sim_n8x300 | tee sim.log
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
